// ==== hyper_cfg.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build-time settings of the HyperBus front end
// Chip count, address map and register reset values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef HYPER_CFG_SVH
`define HYPER_CFG_SVH

// Chips behind the transfer engine
`define HYPER_NUM_CHIPS 2

// Bit 31 of the bus address selects the register window
`define HYPER_CFG_BASE 32'h8000_0000
`define HYPER_NUM_BASE_REGS 8

// Chip ranges after reset
`define HYPER_RST_CHIP_BASE  32'h0000_0000
`define HYPER_RST_CHIP_SPACE 32'h0001_0000  // 64 KiB per chip

// Timing fields after reset
`define HYPER_RST_LAT          6
`define HYPER_RST_LAT_ADD      1
`define HYPER_RST_MASK_MSB     15
`define HYPER_RST_BURST_MAX    350
`define HYPER_RST_RW_RECOVERY  6
`define HYPER_RST_CLK_DELAY    8   // Same for RX and TX
`define HYPER_RST_ADDR_SPACE   0

`endif

// ==== hyper_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the HyperBus front end, imported by every module
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "hyper_cfg.svh"

package hyper_pkg;

    typedef logic [31:0]                  bus_addr_t;
    typedef logic [31:0]                  bus_data_t;
    typedef logic [3:0]                   bus_sel_t;   // Byte enables
    typedef logic [`HYPER_NUM_CHIPS-1:0]  chip_sel_t;  // One bit per chip
    typedef logic [3:0]                   lat_t;

    // Field order matches register indices 0 to 7
    typedef struct packed {
        lat_t        t_latency_access;
        logic        en_latency_additional;
        logic [15:0] t_burst_max;
        logic [3:0]  t_read_write_recovery;
        logic [3:0]  t_rx_clk_delay;
        logic [3:0]  t_tx_clk_delay;
        logic [4:0]  address_mask_msb;
        logic        address_space;
    } hyper_cfg_t;

    typedef struct packed {
        bus_addr_t start_addr;
        bus_addr_t end_addr;    // Not inclusive
    } chip_rule_t;

    typedef enum logic {ARB_IDLE, ARB_OWNED} arb_state_e;

    typedef enum logic [1:0] {XFER_IDLE, XFER_LATENCY, XFER_DONE} xfer_state_e;

endpackage

`default_nettype wire

// ==== hyper_wb_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic link from the arbiter to one target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

interface hyper_wb_if;
    import hyper_pkg::*;

    // Request, driven by the arbiter
    logic      cyc;
    logic      stb;
    logic      we;
    bus_addr_t adr;
    bus_data_t dat_w;
    bus_sel_t  sel;

    // Response, one cycle of ack or err per request
    bus_data_t dat_r;
    logic      ack;
    logic      err;

    modport master (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack, err
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack, err
    );

endinterface

`default_nettype wire

// ==== hyper_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter for two Wishbone hosts
// Routes the granted host to the register or memory target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "hyper_cfg.svh"

module hyper_arbiter (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire logic                  m0_cyc_i,
    input  wire logic                  m0_stb_i,
    input  wire logic                  m0_we_i,
    input  hyper_pkg::bus_addr_t       m0_adr_i,
    input  hyper_pkg::bus_data_t       m0_dat_i,
    input  hyper_pkg::bus_sel_t        m0_sel_i,
    output hyper_pkg::bus_data_t       m0_dat_o,
    output logic                       m0_ack_o,
    output logic                       m0_err_o,
    input  wire logic                  m1_cyc_i,
    input  wire logic                  m1_stb_i,
    input  wire logic                  m1_we_i,
    input  hyper_pkg::bus_addr_t       m1_adr_i,
    input  hyper_pkg::bus_data_t       m1_dat_i,
    input  hyper_pkg::bus_sel_t        m1_sel_i,
    output hyper_pkg::bus_data_t       m1_dat_o,
    output logic                       m1_ack_o,
    output logic                       m1_err_o,
    hyper_wb_if.master                 cfg_bus,
    hyper_wb_if.master                 mem_bus
);
    import hyper_pkg::*;

    arb_state_e state_q;
    logic       grant_q;   // Current or last winner, 1 selects m1
    logic       win;
    logic       owned;
    logic       g_cyc, g_stb, g_we, to_cfg;
    bus_addr_t  g_adr;
    bus_data_t  g_dat, rsp_dat;
    bus_sel_t   g_sel;
    logic       rsp_ack, rsp_err;

    // On a tie the host that lost last time wins
    assign win = (m0_cyc_i && m1_cyc_i) ? ~grant_q : ~m0_cyc_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ARB_IDLE;
            grant_q <= 1'b1;   // m0 takes the first tie
        end else begin
            case (state_q)
                ARB_IDLE: if (m0_cyc_i || m1_cyc_i) begin
                    state_q <= ARB_OWNED;
                    grant_q <= win;
                end
                ARB_OWNED: if (!g_cyc) state_q <= ARB_IDLE;
                default:   state_q <= ARB_IDLE;
            endcase
        end
    end

    assign owned = (state_q == ARB_OWNED);

    // Request mux
    assign g_cyc  = grant_q ? m1_cyc_i : m0_cyc_i;
    assign g_stb  = grant_q ? m1_stb_i : m0_stb_i;
    assign g_we   = grant_q ? m1_we_i  : m0_we_i;
    assign g_adr  = grant_q ? m1_adr_i : m0_adr_i;
    assign g_dat  = grant_q ? m1_dat_i : m0_dat_i;
    assign g_sel  = grant_q ? m1_sel_i : m0_sel_i;
    assign to_cfg = |(g_adr & `HYPER_CFG_BASE);

    assign cfg_bus.cyc   = owned & g_cyc & to_cfg;
    assign cfg_bus.stb   = owned & g_stb & to_cfg;
    assign cfg_bus.we    = g_we;
    assign cfg_bus.adr   = g_adr;
    assign cfg_bus.dat_w = g_dat;
    assign cfg_bus.sel   = g_sel;

    assign mem_bus.cyc   = owned & g_cyc & ~to_cfg;
    assign mem_bus.stb   = owned & g_stb & ~to_cfg;
    assign mem_bus.we    = g_we;
    assign mem_bus.adr   = g_adr;
    assign mem_bus.dat_w = g_dat;
    assign mem_bus.sel   = g_sel;

    // Response back to the granted host only
    assign rsp_ack = to_cfg ? cfg_bus.ack   : mem_bus.ack;
    assign rsp_err = to_cfg ? cfg_bus.err   : mem_bus.err;
    assign rsp_dat = to_cfg ? cfg_bus.dat_r : mem_bus.dat_r;

    assign m0_ack_o = owned & ~grant_q & rsp_ack;
    assign m0_err_o = owned & ~grant_q & rsp_err;
    assign m0_dat_o = grant_q ? '0 : rsp_dat;
    assign m1_ack_o = owned & grant_q & rsp_ack;
    assign m1_err_o = owned & grant_q & rsp_err;
    assign m1_dat_o = grant_q ? rsp_dat : '0;

    a_one_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(m0_ack_o && m1_ack_o));

endmodule

`default_nettype wire

// ==== hyper_cfg_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timing and chip-range registers with byte-lane writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "hyper_cfg.svh"

module hyper_cfg_regs (
    input  wire logic                                 clk_i,
    input  wire logic                                 arst_n_i,
    hyper_wb_if.slave                                 bus,
    output hyper_pkg::hyper_cfg_t                     cfg_o,
    output hyper_pkg::chip_rule_t [`HYPER_NUM_CHIPS-1:0] chip_rules_o
);
    import hyper_pkg::*;

    localparam int unsigned NUM_REGS = `HYPER_NUM_BASE_REGS + 2 * `HYPER_NUM_CHIPS;

    hyper_cfg_t                            cfg_q;
    bus_data_t [`HYPER_NUM_CHIPS-1:0][1:0] crange_q;  // [chip][0 start, 1 end]
    logic [3:0] sel_reg;
    logic [3:0] chip_off;
    logic       mapped, req;
    logic       ack_q, err_q;
    bus_data_t  wmask, rd_data, wr_data, dat_q;

    assign sel_reg  = bus.adr[5:2];
    assign chip_off = sel_reg - 4'(`HYPER_NUM_BASE_REGS);
    assign mapped   = (sel_reg < NUM_REGS);
    assign req      = bus.cyc & bus.stb & ~ack_q & ~err_q;  // One answer per request

    // Zero-extended read value of the selected register
    always_comb begin
        rd_data = '0;
        case (sel_reg)
            4'd0: rd_data = bus_data_t'(cfg_q.t_latency_access);
            4'd1: rd_data = bus_data_t'(cfg_q.en_latency_additional);
            4'd2: rd_data = bus_data_t'(cfg_q.t_burst_max);
            4'd3: rd_data = bus_data_t'(cfg_q.t_read_write_recovery);
            4'd4: rd_data = bus_data_t'(cfg_q.t_rx_clk_delay);
            4'd5: rd_data = bus_data_t'(cfg_q.t_tx_clk_delay);
            4'd6: rd_data = bus_data_t'(cfg_q.address_mask_msb);
            4'd7: rd_data = bus_data_t'(cfg_q.address_space);
            default: if (mapped) rd_data = crange_q[chip_off[3:1]][chip_off[0]];
        endcase
    end

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            wmask[8*b +: 8] = {8{bus.sel[b]}};
        end
    end

    assign wr_data = (wmask & bus.dat_w) | (~wmask & rd_data);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_q <= '{
                t_latency_access:      lat_t'(`HYPER_RST_LAT),
                en_latency_additional: 1'(`HYPER_RST_LAT_ADD),
                t_burst_max:           16'(`HYPER_RST_BURST_MAX),
                t_read_write_recovery: 4'(`HYPER_RST_RW_RECOVERY),
                t_rx_clk_delay:        4'(`HYPER_RST_CLK_DELAY),
                t_tx_clk_delay:        4'(`HYPER_RST_CLK_DELAY),
                address_mask_msb:      5'(`HYPER_RST_MASK_MSB),
                address_space:         1'(`HYPER_RST_ADDR_SPACE)
            };
            for (int i = 0; i < `HYPER_NUM_CHIPS; i++) begin
                crange_q[i][0] <= bus_data_t'(`HYPER_RST_CHIP_BASE + `HYPER_RST_CHIP_SPACE * i);
                crange_q[i][1] <= bus_data_t'(`HYPER_RST_CHIP_BASE
                                              + `HYPER_RST_CHIP_SPACE * (i + 1));
            end
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= req & mapped;
            err_q <= req & ~mapped;
            if (req && mapped && bus.we) begin
                case (sel_reg)
                    4'd0: cfg_q.t_latency_access      <= wr_data[3:0];
                    4'd1: cfg_q.en_latency_additional <= wr_data[0];
                    4'd2: cfg_q.t_burst_max           <= wr_data[15:0];
                    4'd3: cfg_q.t_read_write_recovery <= wr_data[3:0];
                    4'd4: cfg_q.t_rx_clk_delay        <= wr_data[3:0];
                    4'd5: cfg_q.t_tx_clk_delay        <= wr_data[3:0];
                    4'd6: cfg_q.address_mask_msb      <= wr_data[4:0];
                    4'd7: cfg_q.address_space         <= wr_data[0];
                    default: crange_q[chip_off[3:1]][chip_off[0]] <= wr_data;
                endcase
            end
        end
    end

    // Read data lines up with the ack pulse
    always_ff @(posedge clk_i) begin
        if (req) dat_q <= rd_data;
    end

    assign bus.ack   = ack_q;
    assign bus.err   = err_q;
    assign bus.dat_r = dat_q;

    assign cfg_o = cfg_q;
    always_comb begin
        for (int i = 0; i < `HYPER_NUM_CHIPS; i++) begin
            chip_rules_o[i].start_addr = crange_q[i][0];
            chip_rules_o[i].end_addr   = crange_q[i][1];
        end
    end

    a_ack_xor_err: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(bus.ack && bus.err));

endmodule

`default_nettype wire

// ==== hyper_xfer_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Chip decoder and single-word access sequencer
// Holds one chip select for the configured latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "hyper_cfg.svh"

module hyper_xfer_engine (
    input  wire logic                                 clk_i,
    input  wire logic                                 arst_n_i,
    hyper_wb_if.slave                                 bus,
    input  hyper_pkg::hyper_cfg_t                     cfg_i,
    input  hyper_pkg::chip_rule_t [`HYPER_NUM_CHIPS-1:0] chip_rules_i,
    output hyper_pkg::chip_sel_t                      hb_cs_n_o,
    output hyper_pkg::bus_addr_t                      hb_addr_o,
    output hyper_pkg::bus_data_t                      hb_wdata_o,
    output logic                                      hb_we_o,
    input  hyper_pkg::bus_data_t                      hb_rdata_i
);
    import hyper_pkg::*;

    xfer_state_e state_q;
    logic        err_q, req, hit_any, we_q;
    chip_sel_t   hit_sel, cs_sel_q;
    bus_addr_t   hit_start, addr_mask, addr_q;
    bus_data_t   wdata_q, rdata_q;
    logic [4:0]  lat_full, cnt_q;   // Up to twice a 4-bit latency

    assign req = bus.cyc & bus.stb & ~err_q;

    // Lowest matching chip wins
    always_comb begin
        hit_any   = 1'b0;
        hit_sel   = '0;
        hit_start = '0;
        for (int i = `HYPER_NUM_CHIPS - 1; i >= 0; i--) begin
            if (bus.adr >= chip_rules_i[i].start_addr && bus.adr < chip_rules_i[i].end_addr) begin
                hit_any   = 1'b1;
                hit_sel   = chip_sel_t'(1) << i;
                hit_start = chip_rules_i[i].start_addr;
            end
        end
        for (int b = 0; b < 32; b++) begin
            addr_mask[b] = (b <= int'(cfg_i.address_mask_msb));
        end
    end

    always_comb begin
        lat_full = cfg_i.en_latency_additional ? {cfg_i.t_latency_access, 1'b0}
                                               : {1'b0, cfg_i.t_latency_access};
        if (lat_full == '0) lat_full = 5'd1;   // Never shorter than one cycle
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= XFER_IDLE;
            cnt_q   <= '0;
            err_q   <= 1'b0;
        end else begin
            err_q <= 1'b0;
            case (state_q)
                XFER_IDLE: if (req) begin
                    if (hit_any) begin
                        state_q <= XFER_LATENCY;
                        cnt_q   <= lat_full - 5'd1;
                    end else begin
                        err_q <= 1'b1;     // No chip claims the address
                    end
                end
                XFER_LATENCY: begin
                    if (cnt_q == '0) state_q <= XFER_DONE;
                    else             cnt_q   <= cnt_q - 5'd1;
                end
                XFER_DONE: state_q <= XFER_IDLE;
                default:   state_q <= XFER_IDLE;
            endcase
        end
    end

    // Access parameters latched at the start
    always_ff @(posedge clk_i) begin
        if (state_q == XFER_IDLE && req) begin
            cs_sel_q <= hit_sel;
            addr_q   <= (bus.adr - hit_start) & addr_mask;
            we_q     <= bus.we;
            wdata_q  <= bus.dat_w;
        end
        if (state_q == XFER_LATENCY && cnt_q == '0) rdata_q <= hb_rdata_i;  // Last low cycle
    end

    assign hb_cs_n_o  = ~(cs_sel_q & {`HYPER_NUM_CHIPS{state_q == XFER_LATENCY}});
    assign hb_we_o    = we_q & (state_q == XFER_LATENCY);
    assign hb_addr_o  = addr_q;
    assign hb_wdata_o = wdata_q;

    assign bus.ack   = (state_q == XFER_DONE);
    assign bus.err   = err_q;
    assign bus.dat_r = rdata_q;

    a_one_cs: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $countones(~hb_cs_n_o) <= 1);

endmodule

`default_nettype wire

// ==== hyper_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Front end top with two Wishbone hosts and the memory pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "hyper_cfg.svh"

module hyper_top (
    input  wire logic              clk_i,
    input  wire logic              arst_n_i,
    input  wire logic              m0_cyc_i,
    input  wire logic              m0_stb_i,
    input  wire logic              m0_we_i,
    input  hyper_pkg::bus_addr_t   m0_adr_i,
    input  hyper_pkg::bus_data_t   m0_dat_i,
    input  hyper_pkg::bus_sel_t    m0_sel_i,
    output hyper_pkg::bus_data_t   m0_dat_o,
    output logic                   m0_ack_o,
    output logic                   m0_err_o,
    input  wire logic              m1_cyc_i,
    input  wire logic              m1_stb_i,
    input  wire logic              m1_we_i,
    input  hyper_pkg::bus_addr_t   m1_adr_i,
    input  hyper_pkg::bus_data_t   m1_dat_i,
    input  hyper_pkg::bus_sel_t    m1_sel_i,
    output hyper_pkg::bus_data_t   m1_dat_o,
    output logic                   m1_ack_o,
    output logic                   m1_err_o,
    output hyper_pkg::chip_sel_t   hb_cs_n_o,
    output hyper_pkg::bus_addr_t   hb_addr_o,
    output logic                   hb_we_o,
    output hyper_pkg::bus_data_t   hb_wdata_o,
    input  hyper_pkg::bus_data_t   hb_rdata_i
);
    import hyper_pkg::*;

    hyper_cfg_t                            cfg;
    chip_rule_t [`HYPER_NUM_CHIPS-1:0]     chip_rules;

    hyper_wb_if cfg_bus ();
    hyper_wb_if mem_bus ();

    hyper_arbiter i_arbiter (
        .clk_i, .arst_n_i,
        .m0_cyc_i, .m0_stb_i, .m0_we_i, .m0_adr_i, .m0_dat_i, .m0_sel_i,
        .m0_dat_o, .m0_ack_o, .m0_err_o,
        .m1_cyc_i, .m1_stb_i, .m1_we_i, .m1_adr_i, .m1_dat_i, .m1_sel_i,
        .m1_dat_o, .m1_ack_o, .m1_err_o,
        .cfg_bus (cfg_bus.master),
        .mem_bus (mem_bus.master)
    );

    hyper_cfg_regs i_cfg_regs (
        .clk_i, .arst_n_i,
        .bus          (cfg_bus.slave),
        .cfg_o        (cfg),
        .chip_rules_o (chip_rules)
    );

    // Memory side
    hyper_xfer_engine i_xfer_engine (
        .clk_i, .arst_n_i,
        .bus          (mem_bus.slave),
        .cfg_i        (cfg),
        .chip_rules_i (chip_rules),
        .hb_cs_n_o, .hb_addr_o, .hb_wdata_o, .hb_we_o, .hb_rdata_i
    );

endmodule

`default_nettype wire

// ==== tb_hyper_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench of the HyperBus front end
// Two random hosts checked against a register model and a memory model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

`include "hyper_cfg.svh"

module tb_hyper_top;
    import hyper_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_REGS   = `HYPER_NUM_BASE_REGS + 2 * `HYPER_NUM_CHIPS;
    localparam int N_REG      = 40;
    localparam int N_MEM      = 30;
    localparam int N_LAT      = 12;
    localparam int N_UNMAP    = 12;
    localparam int N_DUAL     = 20;
    localparam int N_TXN      = 3 * NUM_REGS + N_REG + 4 + N_MEM + 3 * N_LAT + 4 + N_UNMAP
                                + 2 * N_DUAL;
    localparam int MAX_TXN_CYCLES = 2 * 15 + 6;   // Doubled 4-bit latency plus handshake
    localparam int WATCHDOG_NS    = (N_TXN * MAX_TXN_CYCLES + 3 * 16 + 100) * CLK_PERIOD;

    logic      clk_i, arst_n_i;
    logic      m0_cyc_i, m0_stb_i, m0_we_i, m0_ack_o, m0_err_o;
    logic      m1_cyc_i, m1_stb_i, m1_we_i, m1_ack_o, m1_err_o;
    bus_addr_t m0_adr_i, m1_adr_i, hb_addr_o;
    bus_data_t m0_dat_i, m1_dat_i, m0_dat_o, m1_dat_o;
    bus_sel_t  m0_sel_i, m1_sel_i;
    chip_sel_t hb_cs_n_o;
    logic      hb_we_o;
    bus_data_t hb_wdata_o, hb_rdata_i;

    integer    seed;
    int        data_errs, cs_errs, lat_errs, other_errs;
    bus_data_t reg_model [NUM_REGS];
    bus_data_t mem [bit [39:0]];   // Written words, keyed by chip and address
    int        last_win;           // Host served last
    logic      dual_mode;
    int        dual_next;
    logic      m0_cyc_q, m1_cyc_q;

    // Chip select episode seen by the memory model
    logic      cs_active;
    int        cs_events, cs_len;
    chip_sel_t cs_seen;
    bus_addr_t cs_addr;

    logic      dual_we  [2][N_DUAL];
    bus_addr_t dual_adr [2][N_DUAL];
    bus_data_t dual_dat [2][N_DUAL];
    bus_sel_t  dual_sel [2][N_DUAL];

    hyper_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired, a transaction never completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic report_error(input string msg);
        other_errs++;
        $display("ERROR at %0d ns: %s", $time, msg);
    endtask

    task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("CHECK FAILED at %0d ns: %s = %08h, expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_cs(input string name, input chip_sel_t got, input chip_sel_t exp);
        if (got !== exp) begin
            cs_errs++;
            $display("CHECK FAILED at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_lat(input string name, input lat_t got, input lat_t exp);
        if (got !== exp) begin
            lat_errs++;
            $display("CHECK FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // Width of each register, from the config struct fields
    function automatic bus_data_t field_mask(input int idx);
        case (idx)
            0, 3, 4, 5: return 32'h0000_000F;
            1, 7:       return 32'h0000_0001;
            2:          return 32'h0000_FFFF;
            6:          return 32'h0000_001F;
            default:    return 32'hFFFF_FFFF;   // Chip range words
        endcase
    endfunction

    function automatic bus_data_t mem_word(input int chip, input bus_addr_t a);
        bit [39:0] key;
        key = {8'(chip), a};
        if (mem.exists(key)) return mem[key];
        return (a ^ (32'h5A5A_0000 + chip)) * 32'h9E37_79B1;   // Untouched fill
    endfunction

    function automatic void reset_model();
        reg_model[0] = `HYPER_RST_LAT;
        reg_model[1] = `HYPER_RST_LAT_ADD;
        reg_model[2] = `HYPER_RST_BURST_MAX;
        reg_model[3] = `HYPER_RST_RW_RECOVERY;
        reg_model[4] = `HYPER_RST_CLK_DELAY;
        reg_model[5] = `HYPER_RST_CLK_DELAY;
        reg_model[6] = `HYPER_RST_MASK_MSB;
        reg_model[7] = `HYPER_RST_ADDR_SPACE;
        for (int i = 0; i < `HYPER_NUM_CHIPS; i++) begin
            reg_model[8 + 2 * i] = `HYPER_RST_CHIP_BASE + `HYPER_RST_CHIP_SPACE * i;
            reg_model[9 + 2 * i] = `HYPER_RST_CHIP_BASE + `HYPER_RST_CHIP_SPACE * (i + 1);
        end
    endfunction

    // Lowest chip whose range holds the address, offset masked to the MSB field
    function automatic void decode_addr(input bus_addr_t adr, output logic hit,
                                        output int chip, output bus_addr_t off);
        int        msb;
        bus_addr_t mask;
        msb  = int'(reg_model[6][4:0]);
        mask = (msb == 31) ? 32'hFFFF_FFFF : (32'd1 << (msb + 1)) - 32'd1;
        hit  = 1'b0;
        chip = 0;
        off  = '0;
        for (int i = 0; i < `HYPER_NUM_CHIPS; i++) begin
            if (!hit && adr >= reg_model[8 + 2 * i] && adr < reg_model[9 + 2 * i]) begin
                hit  = 1'b1;
                chip = i;
                off  = (adr - reg_model[8 + 2 * i]) & mask;
            end
        end
    endfunction

    task automatic drive_host(input int h, input logic cyc, input logic we, input bus_addr_t adr,
                              input bus_data_t dat, input bus_sel_t sel);
        if (h == 0) begin
            m0_cyc_i = cyc;
            m0_stb_i = cyc;
            m0_we_i  = we;
            m0_adr_i = adr;
            m0_dat_i = dat;
            m0_sel_i = sel;
        end else begin
            m1_cyc_i = cyc;
            m1_stb_i = cyc;
            m1_we_i  = we;
            m1_adr_i = adr;
            m1_dat_i = dat;
            m1_sel_i = sel;
        end
    endtask

    // One Wishbone classic cycle, returns on the falling edge that shows ack or err
    task automatic bus_access(input int h, input logic we, input bus_addr_t adr,
                              input bus_data_t dat, input bus_sel_t sel,
                              output bus_data_t rdat, output logic got_err);
        logic done;
        @(negedge clk_i);
        drive_host(h, 1'b1, we, adr, dat, sel);
        done = 1'b0;
        while (!done) begin
            @(negedge clk_i);
            done    = (h == 0) ? (m0_ack_o | m0_err_o) : (m1_ack_o | m1_err_o);
            rdat    = (h == 0) ? m0_dat_o : m1_dat_o;
            got_err = (h == 0) ? m0_err_o : m1_err_o;
        end
        drive_host(h, 1'b0, 1'b0, '0, '0, '0);
    endtask

    task automatic run_txn(input int h, input logic we, input bus_addr_t adr,
                           input bus_data_t dat, input bus_sel_t sel);
        bus_data_t rdat;
        bus_data_t wmask;
        logic      got_err;
        logic      hit;
        int        idx;
        int        chip;
        int        events_before;
        int        exp_len;
        bus_addr_t off;
        events_before = cs_events;
        bus_access(h, we, adr, dat, sel, rdat, got_err);
        if (dual_mode) begin
            if (h != dual_next)
                report_error($sformatf("m%0d served out of turn, m%0d was due", h, dual_next));
            dual_next = 1 - h;
        end
        last_win = h;
        if (adr[31]) begin
            idx = int'(adr[5:2]);
            if (idx >= NUM_REGS) begin
                if (!got_err) report_error($sformatf("unmapped register %0d gave no err", idx));
            end else if (got_err) begin
                report_error($sformatf("register %0d answered with err", idx));
            end else if (we) begin
                for (int b = 0; b < 4; b++) wmask[8 * b +: 8] = {8{sel[b]}};
                reg_model[idx] = ((dat & wmask) | (reg_model[idx] & ~wmask)) & field_mask(idx);
            end else begin
                check_data($sformatf("m%0d_dat_o (register %0d)", h, idx), rdat, reg_model[idx]);
            end
        end else begin
            decode_addr(adr, hit, chip, off);
            if (!hit) begin
                if (!got_err) report_error($sformatf("address %08h is unmapped but gave no err", adr));
                if (!dual_mode && cs_events != events_before)
                    report_error($sformatf("chip select went low for unmapped %08h", adr));
            end else if (got_err) begin
                report_error($sformatf("address %08h of chip %0d answered with err", adr, chip));
            end else begin
                if (!dual_mode && cs_events != events_before + 1)
                    report_error("memory access without exactly one chip select pulse");
                check_cs("hb_cs_n_o bits low", cs_seen, chip_sel_t'(1) << chip);
                check_data("hb_addr_o", cs_addr, off);
                exp_len = int'(reg_model[0][3:0]) * (reg_model[1][0] ? 2 : 1);
                if (exp_len == 0) exp_len = 1;
                check_lat("hb_cs_n_o low cycles [3:0]", lat_t'(cs_len), lat_t'(exp_len));
                check_lat("hb_cs_n_o low cycles [7:4]", lat_t'(cs_len >> 4), lat_t'(exp_len >> 4));
                if (we) check_data("memory word", mem_word(chip, off), dat);
                else    check_data($sformatf("m%0d_dat_o", h), rdat, mem_word(chip, off));
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk_i);
        arst_n_i = 1'b0;
        repeat (16) @(negedge clk_i);
        arst_n_i = 1'b1;
        reset_model();
        last_win = 1;   // m0 takes the first tie
    endtask

    function automatic bus_addr_t rand_mem_addr();
        return reg_model[8] + (rand_below(int'(reg_model[11] - reg_model[8])) & ~3);
    endfunction

    // Memory device, answers and records writes while a select is low
    always @(negedge clk_i) begin : mem_model
        chip_sel_t low;
        int        chip;
        low  = ~hb_cs_n_o;
        chip = 0;
        if (arst_n_i && low != '0) begin
            if ($countones(low) > 1) report_error("more than one chip select low");
            for (int i = 0; i < `HYPER_NUM_CHIPS; i++) if (low[i]) chip = i;
            if (!cs_active) begin
                cs_events++;
                cs_len  = 0;
                cs_seen = '0;
                cs_addr = hb_addr_o;
            end
            cs_active = 1'b1;
            cs_len++;
            cs_seen |= low;
            if (hb_we_o) mem[{8'(chip), hb_addr_o}] = hb_wdata_o;
            hb_rdata_i = mem_word(chip, hb_addr_o);
        end else begin
            cs_active  = 1'b0;
            hb_rdata_i = '0;
        end
    end

    always @(negedge clk_i) begin : rsp_monitor
        if (arst_n_i) begin
            if ((m0_ack_o || m0_err_o) && !m0_cyc_i && !m0_cyc_q)
                report_error("m0 got a response without a request");
            if ((m1_ack_o || m1_err_o) && !m1_cyc_i && !m1_cyc_q)
                report_error("m1 got a response without a request");
            if (m0_ack_o && m1_ack_o) report_error("both hosts got ack in one cycle");
        end
        m0_cyc_q = m0_cyc_i;
        m1_cyc_q = m1_cyc_i;
    end

    initial begin
        bus_addr_t start0, end0, start1, end1;
        int        kind;
        seed       = 29;
        arst_n_i   = 1'b0;
        hb_rdata_i = '0;
        data_errs  = 0;
        cs_errs    = 0;
        lat_errs   = 0;
        other_errs = 0;
        cs_active  = 1'b0;
        cs_events  = 0;
        cs_len     = 0;
        cs_seen    = '0;
        cs_addr    = '0;
        dual_mode  = 1'b0;
        dual_next  = 0;
        m0_cyc_q   = 1'b0;
        m1_cyc_q   = 1'b0;
        drive_host(0, 1'b0, 1'b0, '0, '0, '0);
        drive_host(1, 1'b0, 1'b0, '0, '0, '0);
        apply_reset();

        // Reset values
        for (int i = 0; i < NUM_REGS; i++) run_txn(0, 1'b0, `HYPER_CFG_BASE | (i << 2), '0, 4'hF);

        // Byte-masked writes, unmapped ones included, then read-back
        for (int n = 0; n < N_REG; n++)
            run_txn(0, 1'b1, `HYPER_CFG_BASE | (rand_below(16) << 2), $random(seed),
                    bus_sel_t'($random(seed)));
        for (int i = 0; i < NUM_REGS; i++) run_txn(0, 1'b0, `HYPER_CFG_BASE | (i << 2), '0, 4'hF);
        for (int i = 0; i < `HYPER_NUM_CHIPS; i++) begin
            run_txn(0, 1'b1, `HYPER_CFG_BASE | ((8 + 2 * i) << 2),
                    `HYPER_RST_CHIP_BASE + `HYPER_RST_CHIP_SPACE * i, 4'hF);
            run_txn(0, 1'b1, `HYPER_CFG_BASE | ((9 + 2 * i) << 2),
                    `HYPER_RST_CHIP_BASE + `HYPER_RST_CHIP_SPACE * (i + 1), 4'hF);
        end

        // Chip selection and data path
        for (int n = 0; n < N_MEM; n++)
            run_txn(0, 1'($random(seed)), rand_mem_addr(), $random(seed), 4'hF);

        // Latency after random timing writes
        for (int n = 0; n < N_LAT; n++) begin
            run_txn(0, 1'b1, `HYPER_CFG_BASE | (0 << 2), $random(seed), 4'hF);
            run_txn(0, 1'b1, `HYPER_CFG_BASE | (1 << 2), $random(seed), 4'hF);
            run_txn(0, 1'($random(seed)), rand_mem_addr(), $random(seed), 4'hF);
        end

        // New ranges with a gap between the chips
        start0 = 32'h0010_0000 + (rand_below(256) << 8);
        end0   = start0 + 32'h2000;
        start1 = end0 + 32'h1000;
        end1   = start1 + 32'h2000;
        run_txn(0, 1'b1, `HYPER_CFG_BASE | (8 << 2), start0, 4'hF);
        run_txn(0, 1'b1, `HYPER_CFG_BASE | (9 << 2), end0, 4'hF);
        run_txn(0, 1'b1, `HYPER_CFG_BASE | (10 << 2), start1, 4'hF);
        run_txn(0, 1'b1, `HYPER_CFG_BASE | (11 << 2), end1, 4'hF);
        for (int n = 0; n < N_UNMAP; n++) begin
            kind = rand_below(5);
            case (kind)
                0:       run_txn(0, 1'b0, start0 - 4, '0, 4'hF);
                1:       run_txn(0, 1'b1, end0, $random(seed), 4'hF);   // End is exclusive
                2:       run_txn(0, 1'b0, end1 + (rand_below(32'h1000) & ~3), '0, 4'hF);
                3:       run_txn(0, 1'b1, bus_addr_t'($random(seed)) & 32'h000F_FFFC, '0, 4'hF);
                default: run_txn(0, 1'b0, start1 + (rand_below(32'h2000) & ~3), '0, 4'hF);
            endcase
        end

        // Both hosts at once from a fresh reset
        apply_reset();
        for (int h = 0; h < 2; h++) begin
            for (int j = 0; j < N_DUAL; j++) begin
                dual_sel[h][j] = bus_sel_t'($random(seed));
                dual_dat[h][j] = $random(seed);
                if (rand_below(3) == 0) begin
                    kind           = rand_below(14);
                    dual_adr[h][j] = `HYPER_CFG_BASE | (kind << 2);
                    dual_we[h][j]  = (kind < 8) ? 1'($random(seed)) : 1'b0;
                end else begin
                    dual_adr[h][j] = rand_mem_addr();
                    dual_we[h][j]  = 1'($random(seed));
                end
            end
        end
        dual_mode = 1'b1;
        dual_next = 1 - last_win;
        fork
            for (int j = 0; j < N_DUAL; j++)
                run_txn(0, dual_we[0][j], dual_adr[0][j], dual_dat[0][j], dual_sel[0][j]);
            for (int j = 0; j < N_DUAL; j++)
                run_txn(1, dual_we[1][j], dual_adr[1][j], dual_dat[1][j], dual_sel[1][j]);
        join
        dual_mode = 1'b0;

        repeat (2) @(negedge clk_i);
        $display("Errors: data %0d, chip select %0d, latency %0d, other %0d",
                 data_errs, cs_errs, lat_errs, other_errs);
        if (data_errs + cs_errs + lat_errs + other_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
hyper_pkg.sv
hyper_wb_if.sv
hyper_arbiter.sv
hyper_cfg_regs.sv
hyper_xfer_engine.sv
hyper_top.sv
tb_hyper_top.sv

// ==== Bender.yml ====
package:
  name: hyper_frontend

export_include_dirs:
  - .

sources:
  - hyper_pkg.sv
  - hyper_wb_if.sv
  - hyper_arbiter.sv
  - hyper_cfg_regs.sv
  - hyper_xfer_engine.sv
  - hyper_top.sv
  - target: test
    files:
      - tb_hyper_top.sv
